/* mem2axi_pkg.sv */
package mem2axi_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // bus widths
    ////////////////////////////////////////////////////////////////////////////
    localparam int MEM_ADDR_W = 32;
    localparam int MEM_DATA_W = 256;
    localparam int MEM_TYPE_W = 6;
    localparam int AXI_DATA_W = 64;
    localparam int WORD_W     = 32;
    localparam int WORD_BYTES = 4;
    localparam int BEAT_CNT_W = 3;

    // axi side field widths
    localparam int AXI_ID_W    = 4;
    localparam int AXI_LEN_W   = 4;
    localparam int AXI_SIZE_W  = 3;
    localparam int AXI_BURST_W = 2;
    localparam int AXI_STRB_W  = 8;

    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
    typedef logic [MEM_DATA_W-1:0] mem_data_t;
    typedef logic [MEM_TYPE_W-1:0] mem_type_t;
    typedef logic [AXI_DATA_W-1:0] axi_data_t;
    typedef logic [WORD_W-1:0]     axi_word_t;
    typedef logic [BEAT_CNT_W-1:0] beat_cnt_t;

    // fixed fields, every transfer is one 4-byte beat
    localparam logic [AXI_SIZE_W-1:0]  AXI_SIZE_WORD  = 3'b010;
    localparam logic [AXI_BURST_W-1:0] AXI_BURST_INCR = 2'b01;
    localparam logic [AXI_LEN_W-1:0]   AXI_LEN_SINGLE = 4'd0;
    localparam logic [AXI_ID_W-1:0]    AXI_ID_ZERO    = 4'd0;

    // index of the last word for a size code
    function automatic beat_cnt_t last_beat(input mem_type_t code);
        case (code)
            6'h07:   return 3'd1;
            6'h0f:   return 3'd3;
            6'h1f:   return 3'd7;
            default: return 3'd0;
        endcase
    endfunction

    typedef enum logic {RA_IDLE, RA_ISSUE}   rd_addr_state_t;
    typedef enum logic {RD_IDLE, RD_COLLECT} rd_data_state_t;
    typedef enum logic {WA_IDLE, WA_ISSUE}   wr_addr_state_t;
    typedef enum logic {WD_IDLE, WD_ISSUE}   wr_data_state_t;

endpackage

/* read_assembler.sv */
module read_assembler (
    input  logic                   clk,
    input  logic                   rst_n,
    input  mem2axi_pkg::axi_word_t word_i,
    input  logic                   beat_accept_i,
    input  mem2axi_pkg::beat_cnt_t word_idx_i,
    output mem2axi_pkg::mem_data_t line_o
);

    mem2axi_pkg::mem_data_t line_q;
    mem2axi_pkg::mem_data_t line_nxt;

    ////////////////////////////////////////////////////////////////////////////
    // slot insert
    ////////////////////////////////////////////////////////////////////////////

    // current word lands in its slot, the other slots come from the register
    always_comb begin
        line_nxt = line_q;
        line_nxt[word_idx_i*mem2axi_pkg::WORD_W +: mem2axi_pkg::WORD_W] = word_i;
    end

    // visible in the same cycle as the final beat
    assign line_o = line_nxt;

    ////////////////////////////////////////////////////////////////////////////
    // line register
    ////////////////////////////////////////////////////////////////////////////

    // slots past the request length keep old data
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            line_q <= '0;
        end else if (beat_accept_i) begin
            line_q <= line_nxt;
        end
    end

endmodule

/* axi_read_ctrl.sv */
module axi_read_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   r_req_i,
    input  mem2axi_pkg::mem_type_t r_type_i,
    input  mem2axi_pkg::mem_addr_t r_addr_i,
    output logic                   r_rdy_o,
    output mem2axi_pkg::mem_addr_t ar_addr_o,
    output logic                   ar_valid_o,
    input  logic                   ar_ready_i,
    input  logic                   r_valid_i,
    output logic                   r_ready_o,
    output logic                   beat_accept_o,
    output mem2axi_pkg::beat_cnt_t word_idx_o,
    output logic                   re_valid_o
);

    mem2axi_pkg::rd_addr_state_t ra_state;
    mem2axi_pkg::rd_data_state_t rd_state;

    mem2axi_pkg::mem_addr_t base_q;
    mem2axi_pkg::mem_type_t type_q;
    mem2axi_pkg::beat_cnt_t last_idx;
    mem2axi_pkg::beat_cnt_t ar_cnt;
    mem2axi_pkg::beat_cnt_t rd_cnt;

    logic req_fire;
    logic ar_fire;
    logic ar_done;
    logic rd_done;

    assign req_fire = r_req_i && r_rdy_o;
    assign last_idx = mem2axi_pkg::last_beat(type_q);

    // request latch
    always_ff @(posedge clk) begin
        if (req_fire) begin
            base_q <= r_addr_i;
            type_q <= r_type_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // address issue
    ////////////////////////////////////////////////////////////////////////////
    assign ar_valid_o = (ra_state == mem2axi_pkg::RA_ISSUE);
    assign ar_fire    = ar_valid_o && ar_ready_i;
    assign ar_done    = ar_fire && (ar_cnt == last_idx);

    // one word per address, 4 bytes apart
    assign ar_addr_o = base_q
                     + mem2axi_pkg::mem_addr_t'(ar_cnt)
                     * mem2axi_pkg::mem_addr_t'(mem2axi_pkg::WORD_BYTES);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ra_state <= mem2axi_pkg::RA_IDLE;
            ar_cnt   <= '0;
        end else begin
            case (ra_state)
                mem2axi_pkg::RA_IDLE: begin
                    ar_cnt <= '0;
                    if (req_fire) begin
                        ra_state <= mem2axi_pkg::RA_ISSUE;
                    end
                end
                mem2axi_pkg::RA_ISSUE: begin
                    if (ar_done) begin
                        ra_state <= mem2axi_pkg::RA_IDLE;
                    end else if (ar_fire) begin
                        ar_cnt <= ar_cnt + 1'b1;
                    end
                end
                default: ra_state <= mem2axi_pkg::RA_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // data collect
    ////////////////////////////////////////////////////////////////////////////

    // no back-pressure on r while collecting
    assign r_ready_o     = (rd_state == mem2axi_pkg::RD_COLLECT);
    assign beat_accept_o = r_valid_i && r_ready_o;
    assign rd_done       = beat_accept_o && (rd_cnt == last_idx);
    assign word_idx_o    = rd_cnt;
    assign re_valid_o    = rd_done;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_state <= mem2axi_pkg::RD_IDLE;
            rd_cnt   <= '0;
        end else begin
            case (rd_state)
                mem2axi_pkg::RD_IDLE: begin
                    rd_cnt <= '0;
                    if (req_fire) begin
                        rd_state <= mem2axi_pkg::RD_COLLECT;
                    end
                end
                mem2axi_pkg::RD_COLLECT: begin
                    // leave only once the final beat is in
                    if (rd_done) begin
                        rd_state <= mem2axi_pkg::RD_IDLE;
                    end else if (beat_accept_o) begin
                        rd_cnt <= rd_cnt + 1'b1;
                    end
                end
                default: rd_state <= mem2axi_pkg::RD_IDLE;
            endcase
        end
    end

    assign r_rdy_o = (ra_state == mem2axi_pkg::RA_IDLE)
                  && (rd_state == mem2axi_pkg::RD_IDLE);

endmodule

/* axi_write_ctrl.sv */
module axi_write_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   iw_req_i,
    input  mem2axi_pkg::mem_type_t iw_type_i,
    input  mem2axi_pkg::mem_addr_t iw_addr_i,
    input  mem2axi_pkg::mem_data_t iw_data_i,
    output logic                   iw_rdy_o,
    output mem2axi_pkg::mem_addr_t aw_addr_o,
    output logic                   aw_valid_o,
    input  logic                   aw_ready_i,
    output mem2axi_pkg::axi_data_t w_data_o,
    output logic                   w_valid_o,
    input  logic                   w_ready_i
);

    mem2axi_pkg::wr_addr_state_t wa_state;
    mem2axi_pkg::wr_data_state_t wd_state;

    mem2axi_pkg::mem_addr_t addr_q;
    mem2axi_pkg::mem_type_t type_q;
    mem2axi_pkg::mem_data_t line_q;
    mem2axi_pkg::beat_cnt_t last_idx;
    mem2axi_pkg::beat_cnt_t aw_cnt;
    mem2axi_pkg::beat_cnt_t wd_cnt;
    mem2axi_pkg::axi_word_t word_sel;

    logic req_fire;
    logic aw_fire;
    logic aw_done;
    logic w_fire;
    logic w_done;

    assign req_fire = iw_req_i && iw_rdy_o;
    assign last_idx = mem2axi_pkg::last_beat(type_q);

    // request latch, line held until both streams finish
    always_ff @(posedge clk) begin
        if (req_fire) begin
            addr_q <= iw_addr_i;
            type_q <= iw_type_i;
            line_q <= iw_data_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // address stream
    ////////////////////////////////////////////////////////////////////////////
    assign aw_valid_o = (wa_state == mem2axi_pkg::WA_ISSUE);
    assign aw_fire    = aw_valid_o && aw_ready_i;
    assign aw_done    = aw_fire && (aw_cnt == last_idx);

    assign aw_addr_o = addr_q
                     + mem2axi_pkg::mem_addr_t'(aw_cnt)
                     * mem2axi_pkg::mem_addr_t'(mem2axi_pkg::WORD_BYTES);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wa_state <= mem2axi_pkg::WA_IDLE;
            aw_cnt   <= '0;
        end else begin
            case (wa_state)
                mem2axi_pkg::WA_IDLE: begin
                    aw_cnt <= '0;
                    if (req_fire) begin
                        wa_state <= mem2axi_pkg::WA_ISSUE;
                    end
                end
                mem2axi_pkg::WA_ISSUE: begin
                    if (aw_done) begin
                        wa_state <= mem2axi_pkg::WA_IDLE;
                    end else if (aw_fire) begin
                        aw_cnt <= aw_cnt + 1'b1;
                    end
                end
                default: wa_state <= mem2axi_pkg::WA_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // data stream
    ////////////////////////////////////////////////////////////////////////////
    assign w_valid_o = (wd_state == mem2axi_pkg::WD_ISSUE);
    assign w_fire    = w_valid_o && w_ready_i;
    assign w_done    = w_fire && (wd_cnt == last_idx);

    // word k of the line, copied to both lanes
    assign word_sel = line_q[wd_cnt*mem2axi_pkg::WORD_W +: mem2axi_pkg::WORD_W];
    assign w_data_o = {word_sel, word_sel};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wd_state <= mem2axi_pkg::WD_IDLE;
            wd_cnt   <= '0;
        end else begin
            case (wd_state)
                mem2axi_pkg::WD_IDLE: begin
                    wd_cnt <= '0;
                    if (req_fire) begin
                        wd_state <= mem2axi_pkg::WD_ISSUE;
                    end
                end
                mem2axi_pkg::WD_ISSUE: begin
                    if (w_done) begin
                        wd_state <= mem2axi_pkg::WD_IDLE;
                    end else if (w_fire) begin
                        wd_cnt <= wd_cnt + 1'b1;
                    end
                end
                default: wd_state <= mem2axi_pkg::WD_IDLE;
            endcase
        end
    end

    // ready again once the slower stream is done
    assign iw_rdy_o = (wa_state == mem2axi_pkg::WA_IDLE)
                   && (wd_state == mem2axi_pkg::WD_IDLE);

endmodule

/* mem2axi.sv */
module mem2axi (
    input  logic                                   clk,
    input  logic                                   rst_n,
    // memory read port
    input  logic                                   r_req_i,
    input  mem2axi_pkg::mem_type_t                 r_type_i,
    input  mem2axi_pkg::mem_addr_t                 r_addr_i,
    output logic                                   r_rdy_o,
    output mem2axi_pkg::mem_data_t                 re_data_o,
    output logic                                   re_valid_o,
    // memory write port
    input  logic                                   iw_req_i,
    input  mem2axi_pkg::mem_type_t                 iw_type_i,
    input  mem2axi_pkg::mem_addr_t                 iw_addr_i,
    input  mem2axi_pkg::mem_data_t                 iw_data_i,
    output logic                                   iw_rdy_o,
    // axi read address and data
    output mem2axi_pkg::mem_addr_t                 ar_addr_o,
    output logic                                   ar_valid_o,
    output logic [mem2axi_pkg::AXI_ID_W-1:0]       ar_id_o,
    output logic [mem2axi_pkg::AXI_LEN_W-1:0]      ar_len_o,
    output logic [mem2axi_pkg::AXI_SIZE_W-1:0]     ar_size_o,
    output logic [mem2axi_pkg::AXI_BURST_W-1:0]    ar_burst_o,
    input  logic                                   ar_ready_i,
    input  mem2axi_pkg::axi_data_t                 r_data_i,
    input  logic                                   r_valid_i,
    output logic                                   r_ready_o,
    // axi write address, data and response
    output mem2axi_pkg::mem_addr_t                 aw_addr_o,
    output logic                                   aw_valid_o,
    output logic [mem2axi_pkg::AXI_ID_W-1:0]       aw_id_o,
    output logic [mem2axi_pkg::AXI_LEN_W-1:0]      aw_len_o,
    output logic [mem2axi_pkg::AXI_SIZE_W-1:0]     aw_size_o,
    output logic [mem2axi_pkg::AXI_BURST_W-1:0]    aw_burst_o,
    input  logic                                   aw_ready_i,
    output mem2axi_pkg::axi_data_t                 w_data_o,
    output logic [mem2axi_pkg::AXI_STRB_W-1:0]     w_strb_o,
    output logic                                   w_last_o,
    output logic                                   w_valid_o,
    input  logic                                   w_ready_i,
    output logic                                   b_ready_o
);

    logic                   beat_accept;
    mem2axi_pkg::beat_cnt_t word_idx;
    mem2axi_pkg::axi_word_t r_word;

    // only the low lane carries data in 32-bit mode
    assign r_word = r_data_i[mem2axi_pkg::WORD_W-1:0];

    ////////////////////////////////////////////////////////////////////////////
    // read path
    ////////////////////////////////////////////////////////////////////////////
    axi_read_ctrl u_rd_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .r_req_i       (r_req_i),
        .r_type_i      (r_type_i),
        .r_addr_i      (r_addr_i),
        .r_rdy_o       (r_rdy_o),
        .ar_addr_o     (ar_addr_o),
        .ar_valid_o    (ar_valid_o),
        .ar_ready_i    (ar_ready_i),
        .r_valid_i     (r_valid_i),
        .r_ready_o     (r_ready_o),
        .beat_accept_o (beat_accept),
        .word_idx_o    (word_idx),
        .re_valid_o    (re_valid_o)
    );

    read_assembler u_rd_asm (
        .clk           (clk),
        .rst_n         (rst_n),
        .word_i        (r_word),
        .beat_accept_i (beat_accept),
        .word_idx_i    (word_idx),
        .line_o        (re_data_o)
    );

    ////////////////////////////////////////////////////////////////////////////
    // write path
    ////////////////////////////////////////////////////////////////////////////
    axi_write_ctrl u_wr_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .iw_req_i   (iw_req_i),
        .iw_type_i  (iw_type_i),
        .iw_addr_i  (iw_addr_i),
        .iw_data_i  (iw_data_i),
        .iw_rdy_o   (iw_rdy_o),
        .aw_addr_o  (aw_addr_o),
        .aw_valid_o (aw_valid_o),
        .aw_ready_i (aw_ready_i),
        .w_data_o   (w_data_o),
        .w_valid_o  (w_valid_o),
        .w_ready_i  (w_ready_i)
    );

    // fixed fields
    assign ar_id_o    = mem2axi_pkg::AXI_ID_ZERO;
    assign ar_len_o   = mem2axi_pkg::AXI_LEN_SINGLE;
    assign ar_size_o  = mem2axi_pkg::AXI_SIZE_WORD;
    assign ar_burst_o = mem2axi_pkg::AXI_BURST_INCR;
    assign aw_id_o    = mem2axi_pkg::AXI_ID_ZERO;
    assign aw_len_o   = mem2axi_pkg::AXI_LEN_SINGLE;
    assign aw_size_o  = mem2axi_pkg::AXI_SIZE_WORD;
    assign aw_burst_o = mem2axi_pkg::AXI_BURST_INCR;

    // single-beat bursts, so every beat is the last
    assign w_last_o  = w_valid_o;
    assign w_strb_o  = '1;
    assign b_ready_o = 1'b1;

endmodule

/* tb_mem2axi.sv */
module tb_mem2axi;

    localparam int NUM_TESTS       = 5;
    localparam int CYCLES_PER_TEST = 2000;

    // 4-byte size, incr burst, one beat, id 0 as {id, len, size, burst}
    localparam mem2axi_pkg::axi_word_t FIELDS_EXP =
        mem2axi_pkg::axi_word_t'({4'd0, 4'd0, 3'b010, 2'b01});

    logic clk = 1'b0;
    logic rst_n;

    logic                                       r_req_i;
    mem2axi_pkg::mem_type_t                     r_type_i;
    mem2axi_pkg::mem_addr_t                     r_addr_i;
    logic                                       r_rdy_o;
    mem2axi_pkg::mem_data_t                     re_data_o;
    logic                                       re_valid_o;
    logic                                       iw_req_i;
    mem2axi_pkg::mem_type_t                     iw_type_i;
    mem2axi_pkg::mem_addr_t                     iw_addr_i;
    mem2axi_pkg::mem_data_t                     iw_data_i;
    logic                                       iw_rdy_o;
    mem2axi_pkg::mem_addr_t                     ar_addr_o;
    logic                                       ar_valid_o;
    logic [mem2axi_pkg::AXI_ID_W-1:0]           ar_id_o;
    logic [mem2axi_pkg::AXI_LEN_W-1:0]          ar_len_o;
    logic [mem2axi_pkg::AXI_SIZE_W-1:0]         ar_size_o;
    logic [mem2axi_pkg::AXI_BURST_W-1:0]        ar_burst_o;
    logic                                       ar_ready_i;
    mem2axi_pkg::axi_data_t                     r_data_i;
    logic                                       r_valid_i;
    logic                                       r_ready_o;
    mem2axi_pkg::mem_addr_t                     aw_addr_o;
    logic                                       aw_valid_o;
    logic [mem2axi_pkg::AXI_ID_W-1:0]           aw_id_o;
    logic [mem2axi_pkg::AXI_LEN_W-1:0]          aw_len_o;
    logic [mem2axi_pkg::AXI_SIZE_W-1:0]         aw_size_o;
    logic [mem2axi_pkg::AXI_BURST_W-1:0]        aw_burst_o;
    logic                                       aw_ready_i;
    mem2axi_pkg::axi_data_t                     w_data_o;
    logic [mem2axi_pkg::AXI_STRB_W-1:0]         w_strb_o;
    logic                                       w_last_o;
    logic                                       w_valid_o;
    logic                                       w_ready_i;
    logic                                       b_ready_o;

    // slave side records
    mem2axi_pkg::mem_addr_t rd_q[$];
    mem2axi_pkg::mem_addr_t ar_log[$];
    mem2axi_pkg::mem_addr_t aw_log[$];
    mem2axi_pkg::axi_data_t w_log[$];
    mem2axi_pkg::mem_data_t line_cap;
    int                     re_cnt = 0;
    int                     r_beats = 0;
    int                     beats_at_re = 0;
    logic [31:0]            lfsr;

    // positions in the logs where the current transfer starts
    int    ar_mark;
    int    re_mark;
    int    rb_mark;
    int    aw_mark;
    int    w_mark;
    int    reads_issued = 0;
    string cur_test = "setup";

    mem2axi dut0 (.*);

    always #50 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // reference functions
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // words per size code
    function automatic int word_count(input mem2axi_pkg::mem_type_t code);
        case (code)
            6'h07:   return 2;
            6'h0f:   return 4;
            6'h1f:   return 8;
            default: return 1;
        endcase
    endfunction

    // read data returned by the slave for an address
    function automatic mem2axi_pkg::axi_word_t slave_word(input mem2axi_pkg::mem_addr_t addr);
        return {addr[15:0], addr[31:16]} ^ 32'h3c96_a55a;
    endfunction

    function automatic mem2axi_pkg::mem_data_t make_line(input mem2axi_pkg::mem_addr_t base);
        mem2axi_pkg::mem_data_t line;
        for (int k = 0; k < 8; k++) begin
            line[k*32 +: 32] = ~(base + mem2axi_pkg::mem_addr_t'(k * 4)) ^ 32'h0f1e_2d3c;
        end
        return line;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////////////////////
    task automatic stop_on_error();
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_addr(input string what, input mem2axi_pkg::mem_addr_t exp,
                              input mem2axi_pkg::mem_addr_t act);
        if (act !== exp) begin
            $display("ERR %s %s: expected %h, actual %h", cur_test, what, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_word(input string what, input mem2axi_pkg::axi_word_t exp,
                              input mem2axi_pkg::axi_word_t act);
        if (act !== exp) begin
            $display("ERR %s %s: expected %h, actual %h", cur_test, what, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s %s: expected %b, actual %b", cur_test, what, exp, act);
            stop_on_error();
        end
    endtask

    // only the low words covered by the size code
    task automatic check_line(input string what, input mem2axi_pkg::mem_data_t exp,
                              input mem2axi_pkg::mem_data_t act, input int words);
        mem2axi_pkg::mem_data_t mask;
        mask = '0;
        for (int k = 0; k < words; k++) begin
            mask[k*32 +: 32] = '1;
        end
        if ((act & mask) !== (exp & mask)) begin
            $display("ERR %s %s: expected %h, actual %h", cur_test, what,
                     exp & mask, act & mask);
            stop_on_error();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // AXI slave model
    ////////////////////////////////////////////////////////////////////////////

    // random stalls with one lfsr step per bit
    initial begin
        lfsr       = 32'hf7a47c1c;
        ar_ready_i = 1'b0;
        aw_ready_i = 1'b0;
        w_ready_i  = 1'b0;
        r_valid_i  = 1'b0;
        r_data_i   = '0;
        forever begin
            @(negedge clk);
            lfsr       = lfsr_step(lfsr);
            ar_ready_i = lfsr[0];
            lfsr       = lfsr_step(lfsr);
            aw_ready_i = lfsr[0];
            lfsr       = lfsr_step(lfsr);
            w_ready_i  = lfsr[0];
            lfsr       = lfsr_step(lfsr);
            r_valid_i  = lfsr[0] && (rd_q.size() > 0);
            if (rd_q.size() > 0) begin
                // upper lane carries junk the bridge must ignore
                r_data_i = {~slave_word(rd_q[0]), slave_word(rd_q[0])};
            end
        end
    end

    // handshake monitor
    always @(posedge clk) begin
        if (r_valid_i && r_ready_o) begin
            void'(rd_q.pop_front());
            r_beats = r_beats + 1;
        end
        if (ar_valid_o && ar_ready_i) begin
            rd_q.push_back(ar_addr_o);
            ar_log.push_back(ar_addr_o);
            check_word("ar fields", FIELDS_EXP,
                       mem2axi_pkg::axi_word_t'({ar_id_o, ar_len_o, ar_size_o, ar_burst_o}));
        end
        if (aw_valid_o && aw_ready_i) begin
            aw_log.push_back(aw_addr_o);
            check_word("aw fields", FIELDS_EXP,
                       mem2axi_pkg::axi_word_t'({aw_id_o, aw_len_o, aw_size_o, aw_burst_o}));
        end
        if (w_valid_o && w_ready_i) begin
            w_log.push_back(w_data_o);
            check_word("w_strb", 32'h0000_00ff, mem2axi_pkg::axi_word_t'(w_strb_o));
            check_bit("w_last", 1'b1, w_last_o);
        end
        if (re_valid_o) begin
            line_cap    = re_data_o;
            re_cnt      = re_cnt + 1;
            beats_at_re = r_beats;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // request and completion tasks
    ////////////////////////////////////////////////////////////////////////////
    task automatic drive_read(input mem2axi_pkg::mem_type_t code,
                              input mem2axi_pkg::mem_addr_t base);
        ar_mark      = ar_log.size();
        re_mark      = re_cnt;
        rb_mark      = r_beats;
        reads_issued = reads_issued + 1;
        r_req_i      = 1'b1;
        r_type_i     = code;
        r_addr_i     = base;
    endtask

    task automatic drive_write(input mem2axi_pkg::mem_type_t code,
                               input mem2axi_pkg::mem_addr_t base,
                               input mem2axi_pkg::mem_data_t line);
        aw_mark   = aw_log.size();
        w_mark    = w_log.size();
        iw_req_i  = 1'b1;
        iw_type_i = code;
        iw_addr_i = base;
        iw_data_i = line;
    endtask

    task automatic finish_read(input mem2axi_pkg::mem_type_t code,
                               input mem2axi_pkg::mem_addr_t base);
        mem2axi_pkg::mem_data_t exp;
        mem2axi_pkg::mem_addr_t addr;
        int n;
        n   = word_count(code);
        exp = '0;
        while (re_cnt == re_mark) @(negedge clk);
        // the pulse belongs on the last accepted beat
        check_word("beats at re_valid", mem2axi_pkg::axi_word_t'(n),
                   mem2axi_pkg::axi_word_t'(beats_at_re - rb_mark));
        check_bit("r_rdy after last beat", 1'b1, r_rdy_o);
        check_word("read addr count", mem2axi_pkg::axi_word_t'(n),
                   mem2axi_pkg::axi_word_t'(ar_log.size() - ar_mark));
        for (int k = 0; k < n; k++) begin
            addr = base + mem2axi_pkg::mem_addr_t'(k * 4);
            exp[k*32 +: 32] = slave_word(addr);
            check_addr("read addr", addr, ar_log[ar_mark + k]);
        end
        check_line("read line", exp, line_cap, n);
    endtask

    task automatic finish_write(input mem2axi_pkg::mem_type_t code,
                                input mem2axi_pkg::mem_addr_t base,
                                input mem2axi_pkg::mem_data_t line);
        mem2axi_pkg::axi_data_t beat;
        int n;
        n = word_count(code);
        while (!iw_rdy_o) @(negedge clk);
        // iw_rdy must wait for both streams
        check_word("aw count", mem2axi_pkg::axi_word_t'(n),
                   mem2axi_pkg::axi_word_t'(aw_log.size() - aw_mark));
        check_word("w count", mem2axi_pkg::axi_word_t'(n),
                   mem2axi_pkg::axi_word_t'(w_log.size() - w_mark));
        for (int k = 0; k < n; k++) begin
            beat = w_log[w_mark + k];
            check_addr("write addr", base + mem2axi_pkg::mem_addr_t'(k * 4), aw_log[aw_mark + k]);
            check_word("w_data low", line[k*32 +: 32], beat[31:0]);
            check_word("w_data high", line[k*32 +: 32], beat[63:32]);
        end
    endtask

    task automatic run_read(input mem2axi_pkg::mem_type_t code,
                            input mem2axi_pkg::mem_addr_t base);
        while (!r_rdy_o) @(negedge clk);
        drive_read(code, base);
        @(negedge clk);
        r_req_i = 1'b0;
        finish_read(code, base);
    endtask

    task automatic run_write(input mem2axi_pkg::mem_type_t code,
                             input mem2axi_pkg::mem_addr_t base);
        mem2axi_pkg::mem_data_t line;
        line = make_line(base);
        while (!iw_rdy_o) @(negedge clk);
        drive_write(code, base, line);
        @(negedge clk);
        iw_req_i = 1'b0;
        finish_write(code, base, line);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////
    task automatic test_reset();
        cur_test = "reset";
        check_bit("r_rdy", 1'b1, r_rdy_o);
        check_bit("iw_rdy", 1'b1, iw_rdy_o);
        check_bit("ar_valid", 1'b0, ar_valid_o);
        check_bit("aw_valid", 1'b0, aw_valid_o);
        check_bit("w_valid", 1'b0, w_valid_o);
        check_bit("r_ready", 1'b0, r_ready_o);
        check_bit("re_valid", 1'b0, re_valid_o);
        check_bit("b_ready", 1'b1, b_ready_o);
    endtask

    task automatic test_single_reads();
        mem2axi_pkg::mem_type_t codes [5];
        codes    = '{6'h00, 6'h01, 6'h03, 6'h02, 6'h3f};
        cur_test = "single reads";
        foreach (codes[i]) begin
            run_read(codes[i], 32'h0000_1000 + mem2axi_pkg::mem_addr_t'(i * 'h40));
        end
    endtask

    task automatic test_multi_reads();
        mem2axi_pkg::mem_type_t codes [3];
        codes    = '{6'h07, 6'h0f, 6'h1f};
        cur_test = "multi reads";
        foreach (codes[i]) begin
            run_read(codes[i], 32'h8000_0ff0 + mem2axi_pkg::mem_addr_t'(i * 'h100));
        end
    endtask

    task automatic test_writes();
        mem2axi_pkg::mem_type_t codes [8];
        codes    = '{6'h00, 6'h01, 6'h02, 6'h03, 6'h07, 6'h0f, 6'h1f, 6'h3f};
        cur_test = "writes";
        foreach (codes[i]) begin
            run_write(codes[i], 32'h4000_0000 + mem2axi_pkg::mem_addr_t'(i * 'h80));
        end
    endtask

    task automatic test_overlap();
        mem2axi_pkg::mem_data_t line;
        cur_test = "overlap";
        line     = make_line(32'h0000_3000);
        while (!(r_rdy_o && iw_rdy_o)) @(negedge clk);
        drive_read(6'h0f, 32'h0000_2000);
        drive_write(6'h1f, 32'h0000_3000, line);
        @(negedge clk);
        r_req_i  = 1'b0;
        iw_req_i = 1'b0;
        finish_read(6'h0f, 32'h0000_2000);
        finish_write(6'h1f, 32'h0000_3000, line);

        // second read held on r_req behind a long one
        drive_read(6'h1f, 32'h0000_4000);
        @(negedge clk);
        r_type_i = 6'h07;
        r_addr_i = 32'h0000_5000;
        check_bit("r_rdy while busy", 1'b0, r_rdy_o);
        finish_read(6'h1f, 32'h0000_4000);
        drive_read(6'h07, 32'h0000_5000);
        @(negedge clk);
        r_req_i = 1'b0;
        finish_read(6'h07, 32'h0000_5000);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        rst_n     = 1'b0;
        r_req_i   = 1'b0;
        r_type_i  = '0;
        r_addr_i  = '0;
        iw_req_i  = 1'b0;
        iw_type_i = '0;
        iw_addr_i = '0;
        iw_data_i = '0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        test_reset();
        test_single_reads();
        test_multi_reads();
        test_writes();
        test_overlap();
        cur_test = "end";
        check_word("re_valid total", mem2axi_pkg::axi_word_t'(reads_issued),
                   mem2axi_pkg::axi_word_t'(re_cnt));
        $display("No errors");
        $finish;
    end

    initial begin
        repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
        $display("timeout: test %s did not complete in time", cur_test);
        stop_on_error();
    end

endmodule

/* files.f */
mem2axi_pkg.sv
read_assembler.sv
axi_read_ctrl.sv
axi_write_ctrl.sv
mem2axi.sv
tb_mem2axi.sv

/* Makefile */
TOP = tb_mem2axi

.PHONY: all lint clean

all:
	verilator --binary -j 0 --top-module $(TOP) -f files.f -o sim
	@out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -qx "No errors"

lint:
	verilator --lint-only --timing --top-module mem2axi -f files.f

clean:
	rm -rf obj_dir
